/* common/pi1_pkg.sv */
package pi1_pkg;

	// data word width and its byte lanes
	localparam int ARCHBITSZ = 32;
	localparam int SELBITSZ  = ARCHBITSZ/8;

	// word addressing, one memory word per address
	localparam int ADDRBITSZ = 8;
	localparam int MEMDEPTH  = 256;

	// units sharing the memory
	localparam int PUCOUNT = 4;

	// width of an owner index into the units
	localparam int PUIDXBITSZ = $clog2(PUCOUNT);

	// interconnect op encoding
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_RD  = 2'b01,
		PI1_WR  = 2'b10,
		// swap, answered as read-then-write
		PI1_RW  = 2'b11
	} pi1_op_e;

	// one interconnect request, held by the master until rdy
	typedef struct packed {
		pi1_op_e                op;
		logic [ADDRBITSZ-1:0]   addr;
		// write data, ignored on reads
		logic [ARCHBITSZ-1:0]   data;
		// byte lanes to write
		logic [SELBITSZ-1:0]    sel;
	} pi1_req_s;

	// a memory word, seen whole or as byte lanes
	// lane 0 is the least significant byte
	typedef union packed {
		logic [ARCHBITSZ-1:0]         word;
		logic [SELBITSZ-1:0][7:0]     bytes;
	} pi1_word_u;

endpackage

/* mem.hex */
// one line per 16-word region: non-zero data words, zero terminator,
// zero sum slot, then non-zero filler up to the end of the region
a3f1 5e27c 1 ffee 7c0 0 0 b2 41d9 3e 8f00a c41 9d 6 e3 27b
dead 12 beef 3c4d5 f0f0 81 77a 9 c3 0 0 4e2 a0 1b7c 55 f
ff00ff 2a 10203 0 0 5 6a 7b 8c 9d ae bf c0 d1 e2 f3
1234 5678 9abc def0 fedc ba98 7654 3210 abcd ef01 2345 6789 0 0 c3 1e
80808080 7f 31 4444 c 2b2b 9e 0 0 11 22 33 44 55 66 77
101 202 303 404 505 606 707 808 909 a0a b0b c0c d0d e0e 0 0
ffffffff 1 fe 3c 0 0 a b c d e f 10 11 12 13
4f 5e 6d 7c 8b 9a a9 b8 c7 d6 0 0 e5 f4 103 212
c0ffee 1a2b3 77 e0 5d 3 0 0 9 8 7 6 5 4 3 2
2 4 8 10 20 40 80 100 200 400 800 1000 2000 0 0 4000
7e57 ab12 cd34 ef56 0a 1b 2c 3d 0 0 4e 5f 60 71 82 93
1 ff00 0 0 21 32 43 54 65 76 87 98 a9 ba cb dc
99 88 77 66 55 44 33 22 11 aa bb 0 0 cc dd ee
f00d 0ff1ce 5eed 600d d00d 0 0 1 2 3 4 5 6 7 8 9
13 57 9b df 2468 ace0 fdb9 7531 e 0 0 f1 e2 d3 c4 b5
abcdef 0 0 1 2 3 4 5 6 7 8 9 a b c d

/* perint/pi1q.sv */
`timescale 1ns/100ps

module pi1q
	import pi1_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_i,

	// one master port per unit
	input  pi1_req_s            m_req_i [PUCOUNT-1:0],
	output logic [PUCOUNT-1:0]  m_rdy_o,
	output pi1_word_u           m_data_o,

	// single slave port toward the memory
	output pi1_req_s            s_req_o,
	input  logic                s_rdy_i,
	input  pi1_word_u           s_data_i
);

// one-entry slot holding the granted request
pi1_req_s slot_q;
logic     full_q;

// unit owning the slot
logic [PUIDXBITSZ-1:0] owner_q;

// last granted unit, round-robin starts after it
logic [PUIDXBITSZ-1:0] last_q;

// next pending unit in round-robin order
logic [PUIDXBITSZ-1:0] pick_idx;
logic                  pick_vld;

always_comb begin
	logic [PUIDXBITSZ-1:0] cand;
	pick_vld = 1'b0;
	pick_idx = last_q;
	cand     = last_q;
	// last_q itself is tried last, so it gets the lowest priority
	for (int i = 1; i <= PUCOUNT; i++) begin
		cand = PUIDXBITSZ'((int'(last_q) + i) % PUCOUNT);
		if (!pick_vld && m_req_i[cand].op != PI1_NOP) begin
			pick_vld = 1'b1;
			pick_idx = cand;
		end
	end
end

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		full_q    <= 1'b0;
		slot_q.op <= PI1_NOP;
		owner_q   <= '0;
		last_q    <= PUIDXBITSZ'(PUCOUNT-1);
	end else if (full_q) begin
		// slot frees on the edge after the memory answers
		if (s_rdy_i) begin
			full_q    <= 1'b0;
			slot_q.op <= PI1_NOP;
		end
	end else if (pick_vld) begin
		// capture only into an empty slot
		full_q  <= 1'b1;
		slot_q  <= m_req_i[pick_idx];
		owner_q <= pick_idx;
		last_q  <= pick_idx;
	end
end

assign s_req_o = slot_q;

// only the owner sees the memory's rdy
always_comb begin
	m_rdy_o = '0;
	if (full_q) begin
		m_rdy_o[owner_q] = s_rdy_i;
	end
end

// read data goes to every unit, only the owner samples it
assign m_data_o = s_data_i;

a_rdy_onehot: assert property (
	@(posedge clk_i) disable iff (rst_i)
	$onehot0(m_rdy_o)
);

// slot op and fill flag stay in step
a_empty_nop: assert property (
	@(posedge clk_i) disable iff (rst_i)
	!full_q |-> (s_req_o.op == PI1_NOP)
);

// owner keeps its request up while it waits in the slot
a_owner_held: assert property (
	@(posedge clk_i) disable iff (rst_i)
	full_q |-> (m_req_i[owner_q] == slot_q)
);

endmodule

/* pu/pu.sv */
`timescale 1ns/100ps

module pu
	import pi1_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,

	// start pulse and start word address
	input  logic                  intrqst_i,
	input  logic [ADDRBITSZ-1:0]  rstaddr_i,

	// interconnect master side
	output pi1_req_s              req_o,
	input  logic                  rdy_i,
	input  pi1_word_u             data_i,

	output logic                  halted_o,
	output logic [ARCHBITSZ-1:0]  result_o
);

typedef enum logic [1:0] {
	PU_HALT,
	PU_READ,
	PU_WRITE
} pu_state_e;

pu_state_e state_q;

// walk pointer, wraps within the memory
logic [ADDRBITSZ-1:0] addr_q;

// running byte sum of the current walk
logic [ARCHBITSZ-1:0] acc_q;

// last completed sum, shown while halted
logic [ARCHBITSZ-1:0] result_q;

// sum of the four byte lanes of the word being read
logic [ARCHBITSZ-1:0] bsum;

always_comb begin
	bsum = '0;
	for (int i = 0; i < SELBITSZ; i++) begin
		bsum = bsum + ARCHBITSZ'(data_i.bytes[i]);
	end
end

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		state_q  <= PU_HALT;
		addr_q   <= '0;
		acc_q    <= '0;
		result_q <= '0;
	end else begin
		case (state_q)
			PU_HALT: begin
				// start request only counts while halted
				if (intrqst_i) begin
					state_q <= PU_READ;
					addr_q  <= rstaddr_i;
					acc_q   <= '0;
				end
			end
			PU_READ: begin
				if (rdy_i) begin
					// sum slot sits right after the terminator
					addr_q <= addr_q + 1'b1;
					if (data_i.word == '0) begin
						state_q <= PU_WRITE;
					end else begin
						acc_q <= acc_q + bsum;
					end
				end
			end
			PU_WRITE: begin
				if (rdy_i) begin
					state_q  <= PU_HALT;
					result_q <= acc_q;
				end
			end
			default: begin
				state_q <= PU_HALT;
			end
		endcase
	end
end

// request follows the state registers directly
always_comb begin
	req_o      = '0;
	req_o.op   = PI1_NOP;
	req_o.addr = addr_q;
	req_o.data = acc_q;
	if (state_q == PU_READ) begin
		req_o.op  = PI1_RD;
		req_o.sel = '1;
	end else if (state_q == PU_WRITE) begin
		// whole word written, all lanes
		req_o.op  = PI1_WR;
		req_o.sel = '1;
	end
end

assign halted_o = (state_q == PU_HALT);
assign result_o = result_q;

// master holds its request until the slave completes it
a_req_held: assert property (
	@(posedge clk_i) disable iff (rst_i)
	(req_o.op != PI1_NOP && !rdy_i) |=> $stable(req_o)
);

endmodule

/* run.sh */
#!/bin/sh
# build the multipu testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module multipu_tb -f vlog.f -o multipu_sim \
	&& ./obj_dir/multipu_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "simulation run passed" \
	|| { echo "simulation run failed"; exit 1; }

/* src/multipu.sv */
`timescale 1ns/100ps

module multipu
	import pi1_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,

	// per unit start pulse and start address
	input  logic [PUCOUNT-1:0]    intrqst_i,
	input  logic [ADDRBITSZ-1:0]  rstaddr_i [PUCOUNT-1:0],

	// per unit status and last sum
	output logic [PUCOUNT-1:0]    halted_o,
	output logic [ARCHBITSZ-1:0]  result_o [PUCOUNT-1:0]
);

// unit side of the queue
pi1_req_s             pu_req [PUCOUNT-1:0];
logic [PUCOUNT-1:0]   pu_rdy;
pi1_word_u            pu_data;

// memory side of the queue
pi1_req_s             mem_req;
logic                 mem_rdy;
pi1_word_u            mem_data;

genvar genpu_idx;
generate
	for (genpu_idx = 0; genpu_idx < PUCOUNT; genpu_idx++) begin : genpu
		pu pu (
			.clk_i     (clk_i),
			.rst_i     (rst_i),
			.intrqst_i (intrqst_i[genpu_idx]),
			.rstaddr_i (rstaddr_i[genpu_idx]),
			.req_o     (pu_req[genpu_idx]),
			.rdy_i     (pu_rdy[genpu_idx]),
			.data_i    (pu_data),
			.halted_o  (halted_o[genpu_idx]),
			.result_o  (result_o[genpu_idx])
		);
	end
endgenerate

// all units share one memory port through the queue
pi1q pi1q (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.m_req_i  (pu_req),
	.m_rdy_o  (pu_rdy),
	.m_data_o (pu_data),
	.s_req_o  (mem_req),
	.s_rdy_i  (mem_rdy),
	.s_data_i (mem_data)
);

smem smem (
	.clk_i  (clk_i),
	.rst_i  (rst_i),
	.req_i  (mem_req),
	.rdy_o  (mem_rdy),
	.data_o (mem_data)
);

endmodule

/* src/smem.sv */
`timescale 1ns/100ps

module smem
	import pi1_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,

	input  pi1_req_s   req_i,
	output logic       rdy_o,
	output pi1_word_u  data_o
);

pi1_word_u mem [MEMDEPTH-1:0];

// image loaded once at start
initial begin
	$readmemh("mem.hex", mem);
end

// set in the first cycle of a request, cleared in the rdy cycle
logic wait_q;

// write data seen as lanes
pi1_word_u wdata;

// old word with the selected lanes replaced
pi1_word_u merged;

always_ff @(posedge clk_i) begin
	if (rst_i) begin
		wait_q <= 1'b0;
	end else if (wait_q) begin
		wait_q <= 1'b0;
	end else if (req_i.op != PI1_NOP) begin
		wait_q <= 1'b1;
	end
end

assign rdy_o = wait_q;

// read straight from the array, the master samples it in the rdy cycle
// a swap returns the old word since the write lands on the edge
assign data_o = mem[req_i.addr];

always_comb begin
	wdata.word = req_i.data;
	merged     = mem[req_i.addr];
	for (int i = 0; i < SELBITSZ; i++) begin
		if (req_i.sel[i]) begin
			merged.bytes[i] = wdata.bytes[i];
		end
	end
end

// writes and swaps commit on the rdy edge
always_ff @(posedge clk_i) begin
	if (wait_q && (req_i.op == PI1_WR || req_i.op == PI1_RW)) begin
		mem[req_i.addr] <= merged;
	end
end

// the queue drops to NOP only after the rdy cycle
a_rdy_needs_op: assert property (
	@(posedge clk_i) disable iff (rst_i)
	rdy_o |-> (req_i.op != PI1_NOP)
);

endmodule

/* test/multipu_tb.sv */
`timescale 1ns/100ps

module multipu_tb
	import pi1_pkg::*;
();

// cycles any single wait may take
localparam int TIMEOUT = 2000;

// mem.hex holds sixteen regions of sixteen words
localparam int REGIONS     = 16;
localparam int REGIONWORDS = 16;
localparam int ROUNDS      = 20;

logic                 clk_i = 1'b0;
logic                 rst_i;
logic [PUCOUNT-1:0]   intrqst_i;
logic [ADDRBITSZ-1:0] rstaddr_i [PUCOUNT-1:0];
logic [PUCOUNT-1:0]   halted_o;
logic [ARCHBITSZ-1:0] result_o [PUCOUNT-1:0];

// testbench copy of the memory image that follows every write-back
logic [ARCHBITSZ-1:0] model [MEMDEPTH-1:0];

// expected sum and sum slot of each unit as fixed at its start
logic [ARCHBITSZ-1:0] exp_sum [PUCOUNT-1:0];
logic [ADDRBITSZ-1:0] exp_slot [PUCOUNT-1:0];
logic [PUCOUNT-1:0]   pending;
logic [PUCOUNT-1:0]   halted_prev;

// start addresses used by the next start
logic [ADDRBITSZ-1:0] start_addr [PUCOUNT-1:0];

always #10 clk_i = ~clk_i;

multipu UUT (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.intrqst_i (intrqst_i),
	.rstaddr_i (rstaddr_i),
	.halted_o  (halted_o),
	.result_o  (result_o)
);

task automatic abort_run();
	$display("Simulation finished: FAIL");
	$fatal(1, "stopped at the first error");
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
	if (got !== expv) begin
		$display("Fail %s: observed %h, expected %h", name, got, expv);
		abort_run();
	end
endtask

// walk upward from start and add all four bytes of each word up to the zero word
// the sum lands in the word right after the zero word
function automatic logic [ARCHBITSZ-1:0] ref_walk(
	input  logic [ADDRBITSZ-1:0] start,
	input  logic [ARCHBITSZ-1:0] img [MEMDEPTH-1:0],
	output logic [ADDRBITSZ-1:0] slot
);
	logic [ADDRBITSZ-1:0] a;
	logic [ARCHBITSZ-1:0] w;
	logic [ARCHBITSZ-1:0] sum;
	int                   n;
	a   = start;
	sum = '0;
	n   = 0;
	// address wraps within the memory
	while (img[a] != '0 && n < MEMDEPTH) begin
		w   = img[a];
		sum = sum + 32'(w[7:0]) + 32'(w[15:8]) + 32'(w[23:16]) + 32'(w[31:24]);
		a   = a + ADDRBITSZ'(1);
		n++;
	end
	slot = a + ADDRBITSZ'(1);
	return sum;
endfunction

// distinct region starts for every unit
task automatic pick_regions();
	logic [REGIONS-1:0] used;
	int                 r;
	used = '0;
	for (int i = 0; i < PUCOUNT; i++) begin
		r = int'($urandom % REGIONS);
		while (used[r]) begin
			r = (r + 1) % REGIONS;
		end
		used[r]       = 1'b1;
		start_addr[i] = ADDRBITSZ'(r * REGIONWORDS);
	end
endtask

// one-cycle start pulse for the units in mask with expected sums taken from the model
task automatic start_units(input logic [PUCOUNT-1:0] mask);
	logic [ADDRBITSZ-1:0] slot;
	@(posedge clk_i);
	for (int i = 0; i < PUCOUNT; i++) begin
		if (mask[i]) begin
			exp_sum[i]   = ref_walk(start_addr[i], model, slot);
			exp_slot[i]  = slot;
			pending[i]   = 1'b1;
			rstaddr_i[i] <= start_addr[i];
		end
	end
	intrqst_i <= mask;
	@(posedge clk_i);
	intrqst_i <= '0;
endtask

task automatic wait_started(input logic [PUCOUNT-1:0] mask);
	int cycles;
	for (int i = 0; i < PUCOUNT; i++) begin
		cycles = 0;
		while (mask[i] && halted_o[i] && cycles < TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("unit %0d stalled: still halted %0d cycles after its start",
				i, TIMEOUT);
			abort_run();
		end
	end
endtask

task automatic wait_done(input logic [PUCOUNT-1:0] mask);
	int cycles;
	for (int i = 0; i < PUCOUNT; i++) begin
		cycles = 0;
		while (mask[i] && !halted_o[i] && cycles < TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("unit %0d stalled: walk not finished within %0d cycles",
				i, TIMEOUT);
			abort_run();
		end
	end
endtask

task automatic run_walks(input logic [PUCOUNT-1:0] mask);
	start_units(mask);
	wait_started(mask);
	wait_done(mask);
endtask

// compare on every rising halted_o and then mirror the sum write into the model
always @(negedge clk_i) begin
	if (!rst_i) begin
		for (int i = 0; i < PUCOUNT; i++) begin
			if (halted_o[i] && !halted_prev[i]) begin
				if (!pending[i]) begin
					$display("unit %0d finished a walk that was never started",
						i);
					abort_run();
				end else begin
					check($sformatf("result_o[%0d]", i), result_o[i],
						exp_sum[i]);
					model[exp_slot[i]] = exp_sum[i];
					pending[i] = 1'b0;
				end
			end
		end
	end
	halted_prev = halted_o;
end

initial begin
	logic [PUCOUNT-1:0]   mask;
	logic [ADDRBITSZ-1:0] old_slot;
	int                   u;
	int                   alt;
	void'($urandom(32'hc849_23d7));
	$readmemh("mem.hex", model);
	rst_i       = 1'b1;
	intrqst_i   = '0;
	pending     = '0;
	halted_prev = '1;
	for (int i = 0; i < PUCOUNT; i++) begin
		rstaddr_i[i]  = '0;
		start_addr[i] = '0;
	end
	repeat (8) @(posedge clk_i);
	rst_i <= 1'b0;

	// idle after reset with no request toward the memory
	@(negedge clk_i);
	check("halted_o", 32'(halted_o), 32'({PUCOUNT{1'b1}}));
	for (int i = 0; i < PUCOUNT; i++) begin
		check($sformatf("result_o[%0d]", i), result_o[i], '0);
	end
	check("mem_req.op", 32'(UUT.mem_req.op), 32'(PI1_NOP));

	// one unit alone
	u = int'($urandom % PUCOUNT);
	pick_regions();
	mask    = '0;
	mask[u] = 1'b1;
	run_walks(mask);
	old_slot = exp_slot[u];

	// all four at once for arbitration and back-pressure
	pick_regions();
	run_walks('1);

	// restart on a stored sum so the walk runs on into the next region
	start_addr[u] = old_slot;
	run_walks(mask);

	// second start while walking must be ignored
	u = int'($urandom % PUCOUNT);
	pick_regions();
	mask    = '0;
	mask[u] = 1'b1;
	start_units(mask);
	wait_started(mask);
	alt = (u + 1) % PUCOUNT;
	@(posedge clk_i);
	rstaddr_i[u] <= start_addr[alt];
	intrqst_i[u] <= 1'b1;
	@(posedge clk_i);
	intrqst_i <= '0;
	wait_done(mask);

	// random subsets on distinct regions
	for (int round = 0; round < ROUNDS; round++) begin
		mask = PUCOUNT'($urandom % (1 << PUCOUNT));
		if (mask == '0) begin
			mask[int'($urandom % PUCOUNT)] = 1'b1;
		end
		pick_regions();
		run_walks(mask);
	end

	@(posedge clk_i);
	$display("Simulation finished: PASS");
	$finish;
end

endmodule

/* vlog.f */
common/pi1_pkg.sv
pu/pu.sv
perint/pi1q.sv
src/smem.sv
src/multipu.sv
test/multipu_tb.sv
